// File: src/byte_bus_pkg.sv
/*
  Shared types for the byte-serial bridge. The word is fixed at 32 bits and the
  frame at nine byte phases, both set by the pin protocol.
*/
package byte_bus_pkg;

  // Bytes carried per bus word
  localparam int NUM_BYTES = 4;

  // Word width follows from the byte count
  localparam int WORD_W = 8 * NUM_BYTES;

  // Address, write data and read data all use this word
  typedef logic [WORD_W-1:0] word_t;

  // Position inside one frame, numbered as on the pins
  typedef enum logic [3:0] {
    PH_IDLE = 4'd0,  // No frame in flight
    PH_A0   = 4'd1,  // Address byte 0, write data byte 0
    PH_A1   = 4'd2,
    PH_A2   = 4'd3,
    PH_A3   = 4'd4,  // Address byte 3, write data byte 3
    PH_DIR  = 4'd5,  // Direction on uo_out bit 0
    PH_D0   = 4'd6,  // Read byte 0 sampled at the end of this phase
    PH_D1   = 4'd7,
    PH_D2   = 4'd8,
    PH_D3   = 4'd9   // Last phase of every frame
  } phase_t;

  // Reads and writes both run the full frame; the read phases
  // are simply ignored by the CPU port on a write

endpackage

// File: src/cpu_req_if.sv
/*
  Carries one accepted request from the CPU port to the frame logic.
  start is a single-cycle strobe; the other fields hold for the whole frame.
*/
`timescale 1ns/1ps

interface cpu_req_if;

  logic                start;  // Accepted request, one cycle
  byte_bus_pkg::word_t addr;   // Held bus address
  byte_bus_pkg::word_t wdata;  // Held write data
  logic                write;  // 1 for a write frame

  // Request holder drives everything
  modport src (
    output start,
    output addr,
    output wdata,
    output write
  );

  // Phase counter only needs the strobe
  modport seq (
    input start
  );

  // Pin mux needs the payload and direction
  modport pins (
    input addr,
    input wdata,
    input write
  );

endinterface

// File: src/cpu_port.sv
/*
  CPU side of the bridge. One request is held per frame with no queuing;
  a request seen while busy is dropped and flagged on overrun.
*/
`timescale 1ns/1ps

module cpu_port (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  byte_bus_pkg::word_t req_addr,
  input  byte_bus_pkg::word_t req_wdata,
  input  logic                req_write,
  input  byte_bus_pkg::word_t word,
  input  logic                word_valid,
  output logic                done,
  output byte_bus_pkg::word_t rdata,
  output logic                overrun,
  cpu_req_if.src              bus
);

  logic                busy;     // Frame in flight
  logic                accept;   // Request taken this cycle
  logic                start_q;
  logic                write_q;
  byte_bus_pkg::word_t addr_q;
  byte_bus_pkg::word_t wdata_q;

  // A new request may also land in the done cycle
  assign accept = req && (!busy || done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      start_q <= 1'b0;
      write_q <= 1'b0;
      overrun <= 1'b0;
      done    <= 1'b0;
      rdata   <= '0;
    end else begin
      start_q <= accept;
      overrun <= req && !accept;  // Dropped request
      done    <= word_valid;      // Every frame ends with done

      if (accept) begin
        busy    <= 1'b1;
        write_q <= req_write;
      end else if (word_valid) begin
        busy <= 1'b0;
      end

      // Writes leave the last read word in place
      if (word_valid && !write_q) begin
        rdata <= word;
      end
    end
  end

  // Request payload, only meaningful while busy
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  assign bus.start = start_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.write = write_q;

endmodule

// File: src/frame_sequencer.sv
/*
  Steps one frame through its nine phases, one phase per clock.
  phase_next is combinational and leads phase by one cycle.
*/
`timescale 1ns/1ps

module frame_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  cpu_req_if.seq               bus,
  output byte_bus_pkg::phase_t phase,
  output byte_bus_pkg::phase_t phase_next
);

  // Next phase
  always_comb begin
    case (phase)
      byte_bus_pkg::PH_IDLE: begin
        if (bus.start) begin
          phase_next = byte_bus_pkg::PH_A0;  // Frame begins
        end else begin
          phase_next = byte_bus_pkg::PH_IDLE;
        end
      end
      byte_bus_pkg::PH_D3: begin
        phase_next = byte_bus_pkg::PH_IDLE;  // Frame complete
      end
      default: begin
        phase_next = byte_bus_pkg::phase_t'(phase + 4'd1);
      end
    endcase
  end

  // start cannot arrive mid-frame since the CPU port is busy then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= byte_bus_pkg::PH_IDLE;
    end else begin
      phase <= phase_next;
    end
  end

endmodule

// File: src/pin_mux.sv
/*
  Drives the pin side of a frame. Outputs are registered from phase_next so
  they line up with phase; all pins read zero outside a frame.
*/
`timescale 1ns/1ps

module pin_mux (
  input  logic                 clk,
  input  logic                 rst_n,
  cpu_req_if.pins              bus,
  input  byte_bus_pkg::phase_t phase_next,
  output logic [7:0]           uo_out,
  output logic [7:0]           uio_out,
  output logic [7:0]           uio_oe,
  output logic                 sync
);

  logic [1:0] lane;        // Byte lane for the address phases
  logic       addr_phase;  // Coming phase is one of A0..A3
  logic [7:0] uo_d;
  logic [7:0] uio_d;
  logic [7:0] oe_d;
  logic       sync_d;

  always_comb begin
    lane       = 2'd0;
    addr_phase = 1'b1;
    case (phase_next)
      byte_bus_pkg::PH_A0: lane = 2'd0;
      byte_bus_pkg::PH_A1: lane = 2'd1;
      byte_bus_pkg::PH_A2: lane = 2'd2;
      byte_bus_pkg::PH_A3: lane = 2'd3;  // Most significant byte
      default:             addr_phase = 1'b0;
    endcase
  end

  always_comb begin
    uo_d  = '0;
    uio_d = '0;
    oe_d  = '0;
    if (addr_phase) begin
      uo_d = bus.addr[8*lane +: 8];
      if (bus.write) begin
        uio_d = bus.wdata[8*lane +: 8];
        oe_d  = '1;  // Bridge owns uio only for write data
      end
    end else if (phase_next == byte_bus_pkg::PH_DIR) begin
      uo_d = {7'd0, bus.write};  // 1 marks a write
    end
  end

  assign sync_d = (phase_next == byte_bus_pkg::PH_A0);  // Frame marker

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
      sync    <= 1'b0;
    end else begin
      uo_out  <= uo_d;
      uio_out <= uio_d;
      uio_oe  <= oe_d;
      sync    <= sync_d;
    end
  end

endmodule

// File: src/read_assembler.sv
/*
  Builds the read word from uio_in, one byte per read phase, LSB first.
  word_valid fires for every frame; the CPU port decides if the word is used.
*/
`timescale 1ns/1ps

module read_assembler (
  input  logic                 clk,
  input  logic                 rst_n,
  input  byte_bus_pkg::phase_t phase,
  input  logic [7:0]           uio_in,
  output byte_bus_pkg::word_t  word,
  output logic                 word_valid
);

  logic [1:0] lane;     // Lane filled at the end of this phase
  logic       rd_phase; // Current phase is one of D0..D3

  always_comb begin
    lane     = 2'd0;
    rd_phase = 1'b1;
    case (phase)
      byte_bus_pkg::PH_D0: lane = 2'd0;
      byte_bus_pkg::PH_D1: lane = 2'd1;
      byte_bus_pkg::PH_D2: lane = 2'd2;
      byte_bus_pkg::PH_D3: lane = 2'd3;
      default:             rd_phase = 1'b0;
    endcase
  end

  // Byte lanes of the assembled word
  always_ff @(posedge clk) begin
    if (rd_phase) begin
      for (int i = 0; i < byte_bus_pkg::NUM_BYTES; i++) begin
        if (lane == i) begin
          word[8*i +: 8] <= uio_in;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= (phase == byte_bus_pkg::PH_D3);  // Last byte just landed
    end
  end

endmodule

// File: src/byte_bus_bridge.sv
/*
  Byte-serial bus bridge top level. Fixed 11-cycle latency from request to
  done, no back-pressure and no queuing; requests while busy raise overrun.
*/
`timescale 1ns/1ps

module byte_bus_bridge (
  input  logic                clk,
  input  logic                rst_n,
  // CPU side
  input  logic                req,
  input  byte_bus_pkg::word_t req_addr,
  input  byte_bus_pkg::word_t req_wdata,
  input  logic                req_write,
  output logic                done,
  output byte_bus_pkg::word_t rdata,
  output logic                overrun,
  // Pin side
  output logic [7:0]          uo_out,
  input  logic [7:0]          uio_in,
  output logic [7:0]          uio_out,
  output logic [7:0]          uio_oe,
  output logic                sync
);

  byte_bus_pkg::phase_t phase;
  byte_bus_pkg::phase_t phase_next;
  byte_bus_pkg::word_t  word;        // Assembled read word
  logic                 word_valid;

  cpu_req_if req_if ();

  cpu_port u_cpu_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_write  (req_write),
    .word       (word),
    .word_valid (word_valid),
    .done       (done),
    .rdata      (rdata),
    .overrun    (overrun),
    .bus        (req_if.src)
  );

  frame_sequencer u_frame_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (req_if.seq),
    .phase      (phase),
    .phase_next (phase_next)
  );

  pin_mux u_pin_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (req_if.pins),
    .phase_next (phase_next),
    .uo_out     (uo_out),
    .uio_out    (uio_out),
    .uio_oe     (uio_oe),
    .sync       (sync)
  );

  // Samples on the registered phase, one edge behind the pins
  read_assembler u_read_assembler (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .uio_in     (uio_in),
    .word       (word),
    .word_valid (word_valid)
  );

endmodule

// File: verif/byte_bus_bridge_chk.sv
/*
  Protocol assertions, bound into the phase counter and the pin mux.
  The pin rules apply only in an instance that sees the pins.
*/
`timescale 1ns/1ps

module byte_bus_bridge_chk #(
  parameter bit CHECK_PINS = 1'b1  // Instance watches uio_oe and sync
) (
  input logic                 clk,
  input logic                 rst_n,
  input byte_bus_pkg::phase_t phase,
  input logic [7:0]           uio_oe,
  input logic                 sync
);

  int fail_count = 0;  // Assertion failures so far

  if (CHECK_PINS) begin : g_pins
    // Bridge owns the whole uio byte or none of it
    a_oe_whole: assert property (@(posedge clk) disable iff (!rst_n)
      (uio_oe == 8'h00) || (uio_oe == 8'hff))
      else begin
        $error("uio_oe drives a partial byte");
        fail_count++;
      end

    a_sync_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      sync |=> !sync)  // Frame marker is one cycle wide
      else begin
        $error("sync held longer than one cycle");
        fail_count++;
      end
  end

  // Inside a frame the phase moves up by exactly one
  a_phase_step: assert property (@(posedge clk) disable iff (!rst_n)
    (phase != byte_bus_pkg::PH_IDLE && phase != byte_bus_pkg::PH_D3)
      |=> (4'(phase) == 4'($past(phase)) + 4'd1))
    else begin
      $error("phase skipped a step");
      fail_count++;
    end

  a_phase_end: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == byte_bus_pkg::PH_D3) |=> (phase == byte_bus_pkg::PH_IDLE))
    else begin
      $error("phase did not return to idle after D3");
      fail_count++;
    end

  a_phase_start: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == byte_bus_pkg::PH_IDLE)
      |=> (phase == byte_bus_pkg::PH_IDLE || phase == byte_bus_pkg::PH_A0))
    else begin
      $error("frame started past phase A0");
      fail_count++;
    end

endmodule

// Only the phase is watched in the sequencer
bind frame_sequencer byte_bus_bridge_chk #(.CHECK_PINS(1'b0)) chk0 (
  .clk(clk), .rst_n(rst_n), .phase(phase), .uio_oe(8'h00), .sync(1'b0)
);

// phase_next runs one cycle ahead of phase with the same steps
bind pin_mux byte_bus_bridge_chk #(.CHECK_PINS(1'b1)) chk0 (
  .clk(clk), .rst_n(rst_n), .phase(phase_next), .uio_oe(uio_oe), .sync(sync)
);

// File: verif/tb_byte_bus_bridge.sv
/*
  Random reads and writes from a fixed seed, checked against a frame queue and a
  pin-side memory model. Writes go to a pool of 8 addresses with distinct low bits.
*/
`timescale 1ns/1ps

module tb_byte_bus_bridge;

  localparam int CLK_PERIOD   = 100;  // ns
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TXN      = 40;
  localparam int LATENCY      = 11;   // Request edge to done
  localparam int MAX_GAP      = 3;
  localparam int POOL_SIZE    = 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TXN * (LATENCY + 1 + MAX_GAP) + 50;

  typedef struct packed {
    logic                write;
    byte_bus_pkg::word_t addr;
    byte_bus_pkg::word_t wdata;
  } frame_t;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                req;
  byte_bus_pkg::word_t req_addr;
  byte_bus_pkg::word_t req_wdata;
  logic                req_write;
  logic                done;
  byte_bus_pkg::word_t rdata;
  logic                overrun;
  logic [7:0]          uo_out;
  logic [7:0]          uio_in = 8'h00;
  logic [7:0]          uio_out;
  logic [7:0]          uio_oe;
  logic                sync;

  frame_t              frames [$];          // Predicted frames, oldest first
  byte_bus_pkg::word_t pool [POOL_SIZE];
  byte_bus_pkg::word_t ref_data [POOL_SIZE];
  logic                ref_valid [POOL_SIZE];
  byte_bus_pkg::word_t last_rdata = '0;

  // Pin-side memory model, direct mapped on address bits [2:0]
  byte_bus_pkg::word_t pin_tag [POOL_SIZE];
  byte_bus_pkg::word_t pin_data [POOL_SIZE];
  logic                pin_valid [POOL_SIZE];
  int                  pos = 0;             // Frame phase seen on the pins
  frame_t              cur;
  byte_bus_pkg::word_t cap_addr;
  byte_bus_pkg::word_t cap_wdata;
  byte_bus_pkg::word_t rd_word;
  logic [7:0]          exp_uo;
  logic [7:0]          exp_uio;
  logic [7:0]          exp_oe;

  byte_bus_bridge dut0 (
    .clk(clk), .rst_n(rst_n), .req(req), .req_addr(req_addr), .req_wdata(req_wdata),
    .req_write(req_write), .done(done), .rdata(rdata), .overrun(overrun),
    .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out), .uio_oe(uio_oe), .sync(sync)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input string name, input byte_bus_pkg::word_t exp,
                            input byte_bus_pkg::word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  // Content of an address that was never written
  function automatic byte_bus_pkg::word_t unwritten_word(input byte_bus_pkg::word_t a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One request, an optional dropped request while busy, then done
  task automatic run_txn();
    byte_bus_pkg::word_t addr;
    byte_bus_pkg::word_t wdata;
    byte_bus_pkg::word_t exp_rd;
    logic                wr;
    int                  slot;
    int                  drop_k;
    int                  k;
    frame_t              fr;
    wr    = $urandom_range(0, 1);
    slot  = $urandom_range(0, POOL_SIZE - 1);
    addr  = pool[slot];
    wdata = $urandom();
    if (!wr && $urandom_range(0, 3) == 0) begin
      addr = $urandom();  // Almost surely outside the pool
      slot = -1;
    end
    if (wr) begin
      ref_data[slot]  = wdata;
      ref_valid[slot] = 1'b1;
      exp_rd          = last_rdata;  // Writes leave rdata alone
    end else if (slot >= 0 && ref_valid[slot]) begin
      exp_rd = ref_data[slot];
    end else begin
      exp_rd = unwritten_word(addr);
    end
    fr.write = wr;
    fr.addr  = addr;
    fr.wdata = wdata;
    frames.push_back(fr);
    req       = 1'b1;
    req_addr  = addr;
    req_wdata = wdata;
    req_write = wr;
    drop_k = ($urandom_range(0, 2) == 0) ? $urandom_range(0, LATENCY - 1) : -1;
    k = -1;
    do begin
      next_cycle();
      k++;
      req       = (k == drop_k);  // Lands while the frame is busy
      req_addr  = $urandom();
      req_wdata = $urandom();
      req_write = $urandom_range(0, 1);
      check_bit("overrun", (drop_k >= 0) && (k == drop_k + 1), overrun);
      check_bit("done", k == LATENCY, done);
      check_bit("sync", k == 1, sync);  // Frame starts one edge after acceptance
    end while (done !== 1'b1);
    check_word("rdata", exp_rd, rdata);
    if (!wr) begin
      last_rdata = exp_rd;
    end
  endtask

  // Pin monitor, reference compare and memory model, all after the edge settles
  always @(posedge clk) begin
    #1;
    if (pos == 9) begin
      pos = 0;
    end else if (pos != 0) begin
      pos++;
    end else if (sync === 1'b1) begin
      if (frames.size() == 0) begin
        $display("A frame started on the pins with no request pending");
        stop_on_error();
      end
      cur = frames.pop_front();
      pos = 1;
    end
    if (dut0.u_frame_sequencer.chk0.fail_count + dut0.u_pin_mux.chk0.fail_count != 0) begin
      $display("A bound protocol assertion failed");
      stop_on_error();
    end
    exp_uo  = 8'h00;
    exp_uio = 8'h00;
    exp_oe  = 8'h00;
    if (pos >= 1 && pos <= 4) begin
      exp_uo = cur.addr[8*(pos-1) +: 8];  // LSB first
      if (cur.write) begin
        exp_uio = cur.wdata[8*(pos-1) +: 8];
        exp_oe  = 8'hff;
      end
      cap_addr[8*(pos-1) +: 8]  = uo_out;
      cap_wdata[8*(pos-1) +: 8] = uio_out;
    end else if (pos == 5) begin
      exp_uo = {7'd0, cur.write};
      if (uo_out[0]) begin
        pin_tag[cap_addr[2:0]]   = cap_addr;
        pin_data[cap_addr[2:0]]  = cap_wdata;
        pin_valid[cap_addr[2:0]] = 1'b1;
      end else if (pin_valid[cap_addr[2:0]] && pin_tag[cap_addr[2:0]] == cap_addr) begin
        rd_word = pin_data[cap_addr[2:0]];
      end else begin
        rd_word = unwritten_word(cap_addr);
      end
    end
    check_byte("uo_out", exp_uo, uo_out);
    check_byte("uio_out", exp_uio, uio_out);
    check_byte("uio_oe", exp_oe, uio_oe);
    check_bit("sync", pos == 1, sync);
    // Read byte k is taken at the edge after phase 6+k
    uio_in = (pos >= 6 && pos <= 9) ? rd_word[8*(pos-6) +: 8] : 8'ha5;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run is hung", WATCHDOG_CYCLES);
    stop_on_error();
  end

  initial begin
    void'($urandom(32'hd16f));
    rst_n     = 1'b0;
    req       = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_write = 1'b0;
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i]      = ($urandom() & 32'hffff_fff8) | i;  // Distinct low bits
      ref_valid[i] = 1'b0;
      pin_valid[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("done", 1'b0, done);
    check_bit("overrun", 1'b0, overrun);
    check_word("rdata", '0, rdata);
    for (int n = 0; n < NUM_TXN; n++) begin
      run_txn();
      repeat ($urandom_range(0, MAX_GAP)) begin  // Zero gap requests in the done cycle
        next_cycle();
        check_bit("done", 1'b0, done);
        check_bit("overrun", 1'b0, overrun);
      end
    end
    repeat (4) next_cycle();
    if (frames.size() != 0) begin
      $display("%0d predicted frames never appeared on the pins", frames.size());
      stop_on_error();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: byte_bus_bridge.f
src/byte_bus_pkg.sv
src/cpu_req_if.sv
src/cpu_port.sv
src/frame_sequencer.sv
src/pin_mux.sv
src/read_assembler.sv
src/byte_bus_bridge.sv
verif/byte_bus_bridge_chk.sv
verif/tb_byte_bus_bridge.sv
